// File: dual_issue_pkg.sv
`default_nettype none

package dual_issue_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_nop
    } alu_op_e;

    // one word, read either as 3R or as 2RI12
    typedef union packed {
        struct packed {
            logic [16:0]           opcode;
            logic [reg_addr_w-1:0] rk;
            logic [reg_addr_w-1:0] rj;
            logic [reg_addr_w-1:0] rd;
        } fmt_3r;
        struct packed {
            logic [9:0]            opcode;
            logic [11:0]           si12;
            logic [reg_addr_w-1:0] rj;
            logic [reg_addr_w-1:0] rd;
        } fmt_2ri12;
    } inst_word_u;

    // 3R opcodes, bits 31:15
    localparam logic [16:0] opc_add_w = 17'h00020;
    localparam logic [16:0] opc_sub_w = 17'h00022;
    localparam logic [16:0] opc_slt   = 17'h00024;
    localparam logic [16:0] opc_and   = 17'h00029;
    localparam logic [16:0] opc_or    = 17'h0002a;
    localparam logic [16:0] opc_xor   = 17'h0002b;

    // 2RI12 opcodes, bits 31:22
    localparam logic [9:0] opc_addi_w = 10'h00a;
    localparam logic [9:0] opc_andi   = 10'h00d;
    localparam logic [9:0] opc_ori    = 10'h00e;

    // andi r0, r0, 0
    localparam logic [xlen-1:0] inst_nop = 32'h0340_0000;

endpackage

`default_nettype wire

// File: pair_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module pair_decoder (
    input  wire logic [dual_issue_pkg::xlen-1:0]       inst0,
    input  wire logic [dual_issue_pkg::xlen-1:0]       inst1,
    output dual_issue_pkg::alu_op_e                    op0,
    output dual_issue_pkg::alu_op_e                    op1,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] rd0,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] rd1,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] rj0,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] rj1,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] rk0,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] rk1,
    output logic      [dual_issue_pkg::xlen-1:0]       imm0,
    output logic      [dual_issue_pkg::xlen-1:0]       imm1,
    output logic                                       uses_rk0,
    output logic                                       uses_rk1
);
    import dual_issue_pkg::*;

    // shared by both slots
    function automatic void decode_word(
        input  logic [xlen-1:0]       word,
        output alu_op_e               op,
        output logic [reg_addr_w-1:0] rd,
        output logic [reg_addr_w-1:0] rj,
        output logic [reg_addr_w-1:0] rk,
        output logic [xlen-1:0]       imm,
        output logic                  uses_rk
    );
        inst_word_u w;
        w       = word;
        op      = op_nop;
        rd      = '0;
        rj      = '0;
        rk      = '0;
        imm     = '0;
        uses_rk = 1'b0;
        // 3R forms take priority
        case (w.fmt_3r.opcode)
            opc_add_w: op = op_add;
            opc_sub_w: op = op_sub;
            opc_and:   op = op_and;
            opc_or:    op = op_or;
            opc_xor:   op = op_xor;
            opc_slt:   op = op_slt;
            default:   op = op_nop;
        endcase
        if (op != op_nop) begin
            rd      = w.fmt_3r.rd;
            rj      = w.fmt_3r.rj;
            rk      = w.fmt_3r.rk;
            uses_rk = 1'b1;
        end else begin
            case (w.fmt_2ri12.opcode)
                opc_addi_w: begin
                    op  = op_add;
                    imm = {{20{w.fmt_2ri12.si12[11]}}, w.fmt_2ri12.si12};
                end
                // logical immediates are zero extended
                opc_andi: begin
                    op  = op_and;
                    imm = {20'b0, w.fmt_2ri12.si12};
                end
                opc_ori: begin
                    op  = op_or;
                    imm = {20'b0, w.fmt_2ri12.si12};
                end
                default: op = op_nop;
            endcase
            if (op != op_nop) begin
                rd = w.fmt_2ri12.rd;
                rj = w.fmt_2ri12.rj;
            end
        end
    endfunction

    always_comb begin
        decode_word(inst0, op0, rd0, rj0, rk0, imm0, uses_rk0);
        decode_word(inst1, op1, rd1, rj1, rk1, imm1, uses_rk1);
    end

endmodule

`default_nettype wire

// File: issue_splitter.sv
`default_nettype none
`timescale 1ns/1ps

module issue_splitter (
    input  wire logic                                  clk,
    input  wire logic                                  rstn,
    input  wire logic                                  flush,
    input  wire logic                                  in_valid,
    input  wire logic [dual_issue_pkg::xlen-1:0]       in_pc,
    input  wire dual_issue_pkg::alu_op_e               op0,
    input  wire dual_issue_pkg::alu_op_e               op1,
    input  wire logic [dual_issue_pkg::reg_addr_w-1:0] rd0,
    input  wire logic [dual_issue_pkg::reg_addr_w-1:0] rd1,
    input  wire logic [dual_issue_pkg::reg_addr_w-1:0] rj0,
    input  wire logic [dual_issue_pkg::reg_addr_w-1:0] rj1,
    input  wire logic [dual_issue_pkg::reg_addr_w-1:0] rk0,
    input  wire logic [dual_issue_pkg::reg_addr_w-1:0] rk1,
    input  wire logic [dual_issue_pkg::xlen-1:0]       imm0,
    input  wire logic [dual_issue_pkg::xlen-1:0]       imm1,
    input  wire logic                                  uses_rk0,
    input  wire logic                                  uses_rk1,
    output logic                                       in_ready,
    output logic                                       issue_valid0,
    output logic                                       issue_valid1,
    output dual_issue_pkg::alu_op_e                    issue_op0,
    output dual_issue_pkg::alu_op_e                    issue_op1,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] issue_rd0,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] issue_rd1,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] issue_rj0,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] issue_rj1,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] issue_rk0,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] issue_rk1,
    output logic      [dual_issue_pkg::xlen-1:0]       issue_imm0,
    output logic      [dual_issue_pkg::xlen-1:0]       issue_imm1,
    output logic                                       issue_uses_rk0,
    output logic                                       issue_uses_rk1,
    output logic      [dual_issue_pkg::xlen-1:0]       issue_pc0,
    output logic      [dual_issue_pkg::xlen-1:0]       issue_pc1
);
    import dual_issue_pkg::*;

    logic            pair_valid;
    // slot 0 already issued while slot 1 is still held
    logic            second_half;
    logic            dual;
    logic            take;
    logic [xlen-1:0] pc_q;

    // slot 1 independent of slot 0's destination
    assign dual = (issue_rd0 == '0) ||
                  ((issue_rd0 != issue_rj1) && (!issue_uses_rk1 || issue_rd0 != issue_rk1));

    assign in_ready     = !pair_valid || dual || second_half;
    assign take         = in_valid && in_ready && !flush;
    assign issue_valid0 = pair_valid && !second_half;
    assign issue_valid1 = pair_valid && (second_half || dual);
    assign issue_pc0    = pc_q;
    assign issue_pc1    = pc_q + xlen'(4);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pair_valid     <= 1'b0;
            second_half    <= 1'b0;
            pc_q           <= '0;
            issue_op0      <= op_add;
            issue_op1      <= op_add;
            issue_rd0      <= '0;
            issue_rd1      <= '0;
            issue_rj0      <= '0;
            issue_rj1      <= '0;
            issue_rk0      <= '0;
            issue_rk1      <= '0;
            issue_imm0     <= '0;
            issue_imm1     <= '0;
            issue_uses_rk0 <= 1'b0;
            issue_uses_rk1 <= 1'b0;
        end else if (flush) begin
            pair_valid  <= 1'b0;
            second_half <= 1'b0;
        end else if (take) begin
            pair_valid     <= 1'b1;
            second_half    <= 1'b0;
            pc_q           <= in_pc;
            issue_op0      <= op0;
            issue_op1      <= op1;
            issue_rd0      <= rd0;
            issue_rd1      <= rd1;
            issue_rj0      <= rj0;
            issue_rj1      <= rj1;
            issue_rk0      <= rk0;
            issue_rk1      <= rk1;
            issue_imm0     <= imm0;
            issue_imm1     <= imm1;
            issue_uses_rk0 <= uses_rk0;
            issue_uses_rk1 <= uses_rk1;
        end else if (!in_ready) begin
            // slot 1 of a split pair goes next cycle
            second_half <= 1'b1;
        end else begin
            pair_valid  <= 1'b0;
            second_half <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: regfile.sv
`default_nettype none
`timescale 1ns/1ps

module regfile (
    input  wire logic                                  clk,
    input  wire logic                                  rstn,
    input  wire logic [dual_issue_pkg::reg_addr_w-1:0] raddr0,
    input  wire logic [dual_issue_pkg::reg_addr_w-1:0] raddr1,
    input  wire logic [dual_issue_pkg::reg_addr_w-1:0] raddr2,
    input  wire logic [dual_issue_pkg::reg_addr_w-1:0] raddr3,
    input  wire logic                                  we0,
    input  wire logic                                  we1,
    input  wire logic [dual_issue_pkg::reg_addr_w-1:0] waddr0,
    input  wire logic [dual_issue_pkg::reg_addr_w-1:0] waddr1,
    input  wire logic [dual_issue_pkg::xlen-1:0]       wdata0,
    input  wire logic [dual_issue_pkg::xlen-1:0]       wdata1,
    output logic      [dual_issue_pkg::xlen-1:0]       rdata0,
    output logic      [dual_issue_pkg::xlen-1:0]       rdata1,
    output logic      [dual_issue_pkg::xlen-1:0]       rdata2,
    output logic      [dual_issue_pkg::xlen-1:0]       rdata3
);
    import dual_issue_pkg::*;

    logic [xlen-1:0] regs [32];

    // r0 is never written, so it reads zero
    assign rdata0 = regs[raddr0];
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];
    assign rdata3 = regs[raddr3];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 1; i < 32; i++) begin
                // port 1 is the younger slot and wins
                if (we1 && waddr1 == reg_addr_w'(i)) begin
                    regs[i] <= wdata1;
                end else if (we0 && waddr0 == reg_addr_w'(i)) begin
                    regs[i] <= wdata0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: alu_lane.sv
`default_nettype none
`timescale 1ns/1ps

module alu_lane (
    input  wire dual_issue_pkg::alu_op_e         op,
    input  wire logic [dual_issue_pkg::xlen-1:0] src_a,
    input  wire logic [dual_issue_pkg::xlen-1:0] src_b,
    input  wire logic [dual_issue_pkg::xlen-1:0] imm,
    input  wire logic                            uses_rk,
    output logic      [dual_issue_pkg::xlen-1:0] result
);
    import dual_issue_pkg::*;

    logic [xlen-1:0] opnd_b;

    // immediate forms take imm as second operand
    assign opnd_b = uses_rk ? src_b : imm;

    always_comb begin
        case (op)
            op_add:  result = src_a + opnd_b;
            op_sub:  result = src_a - opnd_b;
            op_and:  result = src_a & opnd_b;
            op_or:   result = src_a | opnd_b;
            op_xor:  result = src_a ^ opnd_b;
            op_slt:  result = {31'b0, $signed(src_a) < $signed(opnd_b)};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: writeback_stage.sv
`default_nettype none
`timescale 1ns/1ps

module writeback_stage (
    input  wire logic                                  clk,
    input  wire logic                                  rstn,
    input  wire logic                                  issue_valid0,
    input  wire logic                                  issue_valid1,
    input  wire logic [dual_issue_pkg::reg_addr_w-1:0] rd0,
    input  wire logic [dual_issue_pkg::reg_addr_w-1:0] rd1,
    input  wire logic [dual_issue_pkg::xlen-1:0]       pc0,
    input  wire logic [dual_issue_pkg::xlen-1:0]       pc1,
    input  wire logic [dual_issue_pkg::xlen-1:0]       result0,
    input  wire logic [dual_issue_pkg::xlen-1:0]       result1,
    output logic                                       we0,
    output logic                                       we1,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] waddr0,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] waddr1,
    output logic      [dual_issue_pkg::xlen-1:0]       wdata0,
    output logic      [dual_issue_pkg::xlen-1:0]       wdata1,
    output logic                                       retire_valid0,
    output logic                                       retire_valid1,
    output logic      [dual_issue_pkg::xlen-1:0]       retire_pc0,
    output logic      [dual_issue_pkg::xlen-1:0]       retire_pc1,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] retire_rd0,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] retire_rd1,
    output logic      [dual_issue_pkg::xlen-1:0]       retire_data0,
    output logic      [dual_issue_pkg::xlen-1:0]       retire_data1
);
    import dual_issue_pkg::*;

    // no write for r0 targets
    assign we0    = issue_valid0 && (rd0 != reg_addr_w'(0));
    assign we1    = issue_valid1 && (rd1 != reg_addr_w'(0));
    assign waddr0 = rd0;
    assign waddr1 = rd1;
    assign wdata0 = result0;
    assign wdata1 = result1;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            retire_valid0 <= 1'b0;
            retire_valid1 <= 1'b0;
            retire_pc0    <= '0;
            retire_pc1    <= '0;
            retire_rd0    <= '0;
            retire_rd1    <= '0;
            retire_data0  <= '0;
            retire_data1  <= '0;
        end else begin
            // one-cycle strobes
            retire_valid0 <= issue_valid0;
            retire_valid1 <= issue_valid1;
            retire_pc0    <= pc0;
            retire_pc1    <= pc1;
            retire_rd0    <= rd0;
            retire_rd1    <= rd1;
            retire_data0  <= result0;
            retire_data1  <= result1;
        end
    end

endmodule

`default_nettype wire

// File: dual_issue_core.sv
`default_nettype none
`timescale 1ns/1ps

module dual_issue_core (
    input  wire logic                                  clk,
    input  wire logic                                  rstn,
    input  wire logic                                  flush,
    input  wire logic                                  in_valid,
    output logic                                       in_ready,
    input  wire logic [dual_issue_pkg::xlen-1:0]       in_pc,
    input  wire logic [dual_issue_pkg::xlen-1:0]       in_inst0,
    input  wire logic [dual_issue_pkg::xlen-1:0]       in_inst1,
    output logic                                       retire_valid0,
    output logic                                       retire_valid1,
    output logic      [dual_issue_pkg::xlen-1:0]       retire_pc0,
    output logic      [dual_issue_pkg::xlen-1:0]       retire_pc1,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] retire_rd0,
    output logic      [dual_issue_pkg::reg_addr_w-1:0] retire_rd1,
    output logic      [dual_issue_pkg::xlen-1:0]       retire_data0,
    output logic      [dual_issue_pkg::xlen-1:0]       retire_data1
);
    import dual_issue_pkg::*;

    // decoded pair
    alu_op_e               dec_op0, dec_op1;
    logic [reg_addr_w-1:0] dec_rd0, dec_rd1, dec_rj0, dec_rj1, dec_rk0, dec_rk1;
    logic [xlen-1:0]       dec_imm0, dec_imm1;
    logic                  dec_uses_rk0, dec_uses_rk1;

    // issue slots
    logic                  iss_valid0, iss_valid1;
    alu_op_e               iss_op0, iss_op1;
    logic [reg_addr_w-1:0] iss_rd0, iss_rd1, iss_rj0, iss_rj1, iss_rk0, iss_rk1;
    logic [xlen-1:0]       iss_imm0, iss_imm1, iss_pc0, iss_pc1;
    logic                  iss_uses_rk0, iss_uses_rk1;

    logic [xlen-1:0]       rdata0, rdata1, rdata2, rdata3;
    logic [xlen-1:0]       result0, result1;
    logic                  we0, we1;
    logic [reg_addr_w-1:0] waddr0, waddr1;
    logic [xlen-1:0]       wdata0, wdata1;

    pair_decoder u_decoder (
        .inst0(in_inst0), .inst1(in_inst1),
        .op0(dec_op0), .op1(dec_op1),
        .rd0(dec_rd0), .rd1(dec_rd1), .rj0(dec_rj0), .rj1(dec_rj1),
        .rk0(dec_rk0), .rk1(dec_rk1), .imm0(dec_imm0), .imm1(dec_imm1),
        .uses_rk0(dec_uses_rk0), .uses_rk1(dec_uses_rk1)
    );

    issue_splitter u_splitter (
        .clk, .rstn, .flush, .in_valid, .in_pc, .in_ready,
        .op0(dec_op0), .op1(dec_op1),
        .rd0(dec_rd0), .rd1(dec_rd1), .rj0(dec_rj0), .rj1(dec_rj1),
        .rk0(dec_rk0), .rk1(dec_rk1), .imm0(dec_imm0), .imm1(dec_imm1),
        .uses_rk0(dec_uses_rk0), .uses_rk1(dec_uses_rk1),
        .issue_valid0(iss_valid0), .issue_valid1(iss_valid1),
        .issue_op0(iss_op0), .issue_op1(iss_op1),
        .issue_rd0(iss_rd0), .issue_rd1(iss_rd1),
        .issue_rj0(iss_rj0), .issue_rj1(iss_rj1),
        .issue_rk0(iss_rk0), .issue_rk1(iss_rk1),
        .issue_imm0(iss_imm0), .issue_imm1(iss_imm1),
        .issue_uses_rk0(iss_uses_rk0), .issue_uses_rk1(iss_uses_rk1),
        .issue_pc0(iss_pc0), .issue_pc1(iss_pc1)
    );

    // ports 0/1 feed lane 0, ports 2/3 feed lane 1
    regfile u_regfile (
        .clk, .rstn,
        .raddr0(iss_rj0), .raddr1(iss_rk0), .raddr2(iss_rj1), .raddr3(iss_rk1),
        .we0, .we1, .waddr0, .waddr1, .wdata0, .wdata1,
        .rdata0, .rdata1, .rdata2, .rdata3
    );

    alu_lane u_lane0 (
        .op(iss_op0), .src_a(rdata0), .src_b(rdata1), .imm(iss_imm0),
        .uses_rk(iss_uses_rk0), .result(result0)
    );

    alu_lane u_lane1 (
        .op(iss_op1), .src_a(rdata2), .src_b(rdata3), .imm(iss_imm1),
        .uses_rk(iss_uses_rk1), .result(result1)
    );

    writeback_stage u_writeback (
        .clk, .rstn,
        .issue_valid0(iss_valid0), .issue_valid1(iss_valid1),
        .rd0(iss_rd0), .rd1(iss_rd1), .pc0(iss_pc0), .pc1(iss_pc1),
        .result0, .result1,
        .we0, .we1, .waddr0, .waddr1, .wdata0, .wdata1,
        .retire_valid0, .retire_valid1, .retire_pc0, .retire_pc1,
        .retire_rd0, .retire_rd1, .retire_data0, .retire_data1
    );

endmodule

`default_nettype wire

// File: tb_dual_issue_core.sv
`default_nettype none
`timescale 1ns/1ps

module tb_dual_issue_core;
    import dual_issue_pkg::*;

    localparam int n_directed  = 10;
    localparam int n_random    = 200;
    localparam int total_pairs = n_directed + n_random;
    localparam int watchdog_ns = (total_pairs * 3 + 50) * 40;

    // one expected retire cycle, both ports
    typedef struct packed {
        logic [31:0] cyc;
        logic        v0;
        logic        v1;
        logic [31:0] pc0;
        logic [4:0]  rd0;
        logic [31:0] d0;
        logic [31:0] pc1;
        logic [4:0]  rd1;
        logic [31:0] d1;
    } retire_t;

    logic        clk;
    logic        rstn;
    logic        flush;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_pc;
    logic [31:0] in_inst0;
    logic [31:0] in_inst1;
    logic        retire_valid0;
    logic        retire_valid1;
    logic [31:0] retire_pc0;
    logic [31:0] retire_pc1;
    logic [4:0]  retire_rd0;
    logic [4:0]  retire_rd1;
    logic [31:0] retire_data0;
    logic [31:0] retire_data1;

    int          cycle = 0;
    int          checks;
    int          errors;
    int          test_base;
    int          pair_count;
    int          exp_stall;
    logic [15:0] lfsr;
    logic [31:0] next_pc;
    logic [31:0] model_regs [32];
    retire_t     exp_q [$];

    dual_issue_core u_dut (
        .clk(clk), .rstn(rstn), .flush(flush),
        .in_valid(in_valid), .in_ready(in_ready),
        .in_pc(in_pc), .in_inst0(in_inst0), .in_inst1(in_inst1),
        .retire_valid0(retire_valid0), .retire_valid1(retire_valid1),
        .retire_pc0(retire_pc0), .retire_pc1(retire_pc1),
        .retire_rd0(retire_rd0), .retire_rd1(retire_rd1),
        .retire_data0(retire_data0), .retire_data1(retire_data1)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // rising edges seen so far
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // taps 16 14 13 11
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [31:0] three_reg_word(input logic [16:0] opc, input logic [4:0] rd,
                                                   input logic [4:0] rj, input logic [4:0] rk);
        return {opc, rk, rj, rd};
    endfunction

    function automatic logic [31:0] reg_imm_word(input logic [9:0] opc, input logic [4:0] rd,
                                                 input logic [4:0] rj, input logic [11:0] si12);
        return {opc, si12, rj, rd};
    endfunction

    // small register range so hazards come up often
    function automatic logic [31:0] make_random_inst();
        logic [3:0]  k;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [11:0] si12;
        logic [31:0] w;
        k    = 4'(take_bits(4));
        rd   = 5'(take_bits(3));
        rj   = 5'(take_bits(3));
        rk   = 5'(take_bits(3));
        si12 = 12'(take_bits(12));
        case (k)
            4'd0:    w = three_reg_word(opc_add_w, rd, rj, rk);
            4'd1:    w = three_reg_word(opc_sub_w, rd, rj, rk);
            4'd2:    w = three_reg_word(opc_and, rd, rj, rk);
            4'd3:    w = three_reg_word(opc_or, rd, rj, rk);
            4'd4:    w = three_reg_word(opc_xor, rd, rj, rk);
            4'd5:    w = three_reg_word(opc_slt, rd, rj, rk);
            4'd6, 4'd7, 4'd8, 4'd9: w = reg_imm_word(opc_addi_w, rd, rj, si12);
            4'd10, 4'd11: w = reg_imm_word(opc_andi, rd, rj, si12);
            4'd12, 4'd13: w = reg_imm_word(opc_ori, rd, rj, si12);
            // top nibble set, matches no opcode
            default: w = {4'hf, 28'(take_bits(28))};
        endcase
        return w;
    endfunction

    // kind 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt, 6 nop
    function automatic void split_fields(
        input  logic [31:0] w,
        output int          kind,
        output logic [4:0]  rd,
        output logic [4:0]  rj,
        output logic [4:0]  rk,
        output logic [31:0] imm,
        output logic        uses_rk
    );
        kind    = 6;
        rd      = '0;
        rj      = '0;
        rk      = '0;
        imm     = '0;
        uses_rk = 1'b0;
        case (w[31:15])
            opc_add_w: kind = 0;
            opc_sub_w: kind = 1;
            opc_and:   kind = 2;
            opc_or:    kind = 3;
            opc_xor:   kind = 4;
            opc_slt:   kind = 5;
            default:   kind = 6;
        endcase
        if (kind != 6) begin
            rd      = w[4:0];
            rj      = w[9:5];
            rk      = w[14:10];
            uses_rk = 1'b1;
        end else begin
            if (w[31:22] == opc_addi_w) begin
                kind = 0;
                imm  = {{20{w[21]}}, w[21:10]};
            end else if (w[31:22] == opc_andi) begin
                kind = 2;
                imm  = {20'b0, w[21:10]};
            end else if (w[31:22] == opc_ori) begin
                kind = 3;
                imm  = {20'b0, w[21:10]};
            end
            if (kind != 6) begin
                rd = w[4:0];
                rj = w[9:5];
            end
        end
    endfunction

    function automatic logic [31:0] compute_op(input int kind, input logic [31:0] a,
                                               input logic [31:0] b);
        case (kind)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            5:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    // reference model, updates the register copy in slot order
    function automatic void predict_pair(
        input  logic [31:0] i0,
        input  logic [31:0] i1,
        input  logic        drop_second,
        output logic        dual,
        output logic [4:0]  rd0,
        output logic [31:0] d0,
        output logic [4:0]  rd1,
        output logic [31:0] d1
    );
        int          k0;
        int          k1;
        logic [4:0]  rj0, rk0, rj1, rk1;
        logic [31:0] imm0, imm1;
        logic        urk0, urk1;
        split_fields(i0, k0, rd0, rj0, rk0, imm0, urk0);
        split_fields(i1, k1, rd1, rj1, rk1, imm1, urk1);
        dual = (rd0 == 5'd0) || (rd0 != rj1 && (!urk1 || rd0 != rk1));
        d0   = compute_op(k0, model_regs[rj0], urk0 ? model_regs[rk0] : imm0);
        if (rd0 != 5'd0) begin
            model_regs[rd0] = d0;
        end
        d1 = compute_op(k1, model_regs[rj1], urk1 ? model_regs[rk1] : imm1);
        if (rd1 != 5'd0 && (dual || !drop_second)) begin
            model_regs[rd1] = d1;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t ns %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic offer_pair(input logic [31:0] i0, input logic [31:0] i1,
                              input logic flush_second);
        int          waited;
        logic        dual;
        logic [4:0]  rd0;
        logic [4:0]  rd1;
        logic [31:0] d0;
        logic [31:0] d1;
        logic [31:0] pc;
        retire_t     e;
        waited   = 0;
        pc       = next_pc;
        next_pc  = next_pc + 32'd8;
        in_valid = 1'b1;
        in_pc    = pc;
        in_inst0 = i0;
        in_inst1 = i1;
        while (!in_ready) begin
            waited++;
            @(negedge clk);
        end
        checks++;
        if (waited != exp_stall) begin
            errors++;
            $display("in_ready was low for %0d cycles before %0t ns, expected %0d",
                     waited, $time, exp_stall);
        end
        @(negedge clk);
        in_valid = 1'b0;
        pair_count++;
        predict_pair(i0, i1, flush_second, dual, rd0, d0, rd1, d1);
        e.cyc = cycle + 1;
        e.v0  = 1'b1;
        e.v1  = dual;
        e.pc0 = pc;
        e.rd0 = rd0;
        e.d0  = d0;
        e.pc1 = pc + 32'd4;
        e.rd1 = rd1;
        e.d1  = d1;
        exp_q.push_back(e);
        if (!dual && flush_second) begin
            // slot 1 still pending at this edge
            flush = 1'b1;
            @(negedge clk);
            flush     = 1'b0;
            exp_stall = 0;
        end else if (!dual) begin
            e.cyc = cycle + 2;
            e.v0  = 1'b0;
            e.v1  = 1'b1;
            exp_q.push_back(e);
            exp_stall = 1;
        end else begin
            exp_stall = 0;
        end
    endtask

    task automatic close_test(input string name);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        exp_stall = 0;
        if (errors == test_base) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_base);
        end
        test_base = errors;
    endtask

    initial begin : compare
        retire_t e;
        forever begin
            @(negedge clk);
            while (exp_q.size() != 0 && exp_q[0].cyc < cycle) begin
                e = exp_q.pop_front();
                errors++;
                $display("retire of the pair at pc %h never came, it was due in cycle %0d",
                         e.pc0, e.cyc);
            end
            if (retire_valid0 || retire_valid1) begin
                if (exp_q.size() == 0 || exp_q[0].cyc != cycle) begin
                    errors++;
                    $display("unexpected retire at %0t ns with pc %h and %h",
                             $time, retire_pc0, retire_pc1);
                end else begin
                    e = exp_q.pop_front();
                    check_value("retire_valid0", 32'(e.v0), 32'(retire_valid0));
                    check_value("retire_valid1", 32'(e.v1), 32'(retire_valid1));
                    if (e.v0) begin
                        check_value("retire_pc0", e.pc0, retire_pc0);
                        check_value("retire_rd0", 32'(e.rd0), 32'(retire_rd0));
                        check_value("retire_data0", e.d0, retire_data0);
                    end
                    if (e.v1) begin
                        check_value("retire_pc1", e.pc1, retire_pc1);
                        check_value("retire_rd1", 32'(e.rd1), 32'(retire_rd1));
                        check_value("retire_data1", e.d1, retire_data1);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
        $display("Checks failed");
        $finish;
    end

    initial begin : main
        logic [31:0] w0;
        logic [31:0] w1;
        rstn       = 1'b0;
        flush      = 1'b0;
        in_valid   = 1'b0;
        in_pc      = '0;
        in_inst0   = inst_nop;
        in_inst1   = inst_nop;
        checks     = 0;
        errors     = 0;
        test_base  = 0;
        pair_count = 0;
        exp_stall  = 0;
        lfsr       = 16'd73;
        next_pc    = 32'h1c00_0000;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(negedge clk);
        rstn = 1'b1;

        check_value("in_ready", 32'd1, 32'(in_ready));
        check_value("retire_valid0", 32'd0, 32'(retire_valid0));
        check_value("retire_valid1", 32'd0, 32'(retire_valid1));
        repeat (4) @(negedge clk);
        check_value("in_ready", 32'd1, 32'(in_ready));
        close_test("reset_state");

        offer_pair(reg_imm_word(opc_addi_w, 5'd1, 5'd0, 12'd5),
                   reg_imm_word(opc_addi_w, 5'd2, 5'd0, 12'hffd), 1'b0);
        offer_pair(three_reg_word(opc_add_w, 5'd3, 5'd1, 5'd2),
                   reg_imm_word(opc_ori, 5'd4, 5'd0, 12'h7ff), 1'b0);
        close_test("independent_pairs");

        // rj hazard, then rk hazard, then a dual pair straight after
        offer_pair(reg_imm_word(opc_addi_w, 5'd5, 5'd0, 12'd100),
                   three_reg_word(opc_sub_w, 5'd6, 5'd5, 5'd1), 1'b0);
        offer_pair(three_reg_word(opc_or, 5'd7, 5'd1, 5'd2),
                   three_reg_word(opc_slt, 5'd8, 5'd2, 5'd7), 1'b0);
        offer_pair(reg_imm_word(opc_addi_w, 5'd1, 5'd6, 12'd1),
                   three_reg_word(opc_xor, 5'd2, 5'd8, 5'd6), 1'b0);
        close_test("dependent_pairs");

        offer_pair(reg_imm_word(opc_addi_w, 5'd9, 5'd0, 12'd11),
                   reg_imm_word(opc_addi_w, 5'd9, 5'd0, 12'd22), 1'b0);
        offer_pair(reg_imm_word(opc_addi_w, 5'd0, 5'd0, 12'd55),
                   three_reg_word(opc_add_w, 5'd10, 5'd9, 5'd0), 1'b0);
        offer_pair(three_reg_word(opc_or, 5'd11, 5'd0, 5'd9),
                   three_reg_word(opc_sub_w, 5'd12, 5'd10, 5'd0), 1'b0);
        close_test("same_rd_and_r0");

        offer_pair(reg_imm_word(opc_addi_w, 5'd14, 5'd0, 12'd7),
                   three_reg_word(opc_add_w, 5'd15, 5'd14, 5'd14), 1'b1);
        offer_pair(three_reg_word(opc_add_w, 5'd16, 5'd15, 5'd14),
                   reg_imm_word(opc_addi_w, 5'd17, 5'd15, 12'd1), 1'b0);
        close_test("flush_second_slot");

        for (int n = 0; n < n_random; n++) begin
            w0 = make_random_inst();
            w1 = make_random_inst();
            offer_pair(w0, w1, 1'b0);
        end
        close_test("random_pairs");

        $display("checks %0d, errors %0d, pairs %0d", checks, errors, pair_count);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dual_issue_core.f
dual_issue_pkg.sv
pair_decoder.sv
issue_splitter.sv
regfile.sv
alu_lane.sv
writeback_stage.sv
dual_issue_core.sv
tb_dual_issue_core.sv

// File: Bender.yml
package:
  name: dual_issue_core

sources:
  - dual_issue_pkg.sv
  - pair_decoder.sv
  - issue_splitter.sv
  - regfile.sv
  - alu_lane.sv
  - writeback_stage.sv
  - dual_issue_core.sv
  - target: test
    files:
      - tb_dual_issue_core.sv
